// File: verilog/control_pkg.sv
// frame constants, bus vector types and state machine encodings for the command node
package control_pkg;

  // ----------------------------------------
  // vector types
  // ----------------------------------------
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] fx_addr_t;
  typedef logic [5:0]  mod_id_t;

  // ----------------------------------------
  // frame and routing constants
  // ----------------------------------------
  localparam byte_t SYNC_BYTE   = 8'hA5;
  localparam byte_t DEV_FACTORY = 8'h00;
  localparam byte_t DEV_BCAST   = 8'hFF;
  localparam byte_t DEV_ID_RST  = 8'h01;

  // bit 7 of the module byte flags a read and bits 5..0 select the module
  localparam int READ_BIT = 7;
  localparam int CFG_MOD  = 0;

  // line timing
  localparam int BIT_US      = 4;
  localparam int BIT_CLKS    = 100;
  localparam int FRAME_BYTES = 6;

  // ----------------------------------------
  // state encodings
  // ----------------------------------------
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;
  typedef enum logic [2:0] {P_SYNC, P_DEV, P_MOD, P_ADDR, P_DATA, P_CHK} parse_state_t;

endpackage

// File: verilog/rx_ctrl_top.sv
// uart receiver on the us strobe, frame parser and checksum check
`timescale 1ns/1ps

module rx_ctrl_top import control_pkg::*; (
  input  logic  rx_ctrl,
  output byte_t cmdr_dev,
  output byte_t cmdr_mod,
  output byte_t cmdr_addr,
  output byte_t cmdr_data,
  output logic  cmdr_vld,
  input  logic  clk_sys,
  input  logic  pluse_us,
  input  logic  rst
);

  localparam int CW = $clog2(BIT_US);
  localparam logic [CW-1:0] HALF_LAST = CW'(BIT_US / 2 - 1);
  localparam logic [CW-1:0] FULL_LAST = CW'(BIT_US - 1);

  logic         rx_s1;
  logic         rx_s2;
  logic         rx_d;
  rx_state_t    rx_state;
  logic [CW-1:0] us_cnt;
  logic [2:0]   bit_cnt;
  byte_t        rx_byte;
  logic         byte_vld;
  parse_state_t pstate;
  byte_t        chk;
  logic         mid_bit;

  // ----------------------------------------
  // line sync and bit timing
  // ----------------------------------------
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end else begin
      rx_s1 <= rx_ctrl;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  // sample point of data and stop bits after a full bit period
  assign mid_bit = pluse_us && (us_cnt == FULL_LAST);

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      rx_state <= RX_IDLE;
      us_cnt   <= '0;
      bit_cnt  <= '0;
      byte_vld <= 1'b0;
    end else begin
      byte_vld <= 1'b0;
      case (rx_state)
        RX_IDLE: begin
          // falling edge opens a start bit
          if (rx_d && !rx_s2) begin
            rx_state <= RX_START;
            us_cnt   <= '0;
          end
        end
        RX_START: begin
          if (pluse_us) begin
            if (us_cnt == HALF_LAST) begin
              us_cnt   <= '0;
              bit_cnt  <= '0;
              // glitch if line is back high at mid start bit
              rx_state <= rx_s2 ? RX_IDLE : RX_DATA;
            end else begin
              us_cnt <= us_cnt + 1'b1;
            end
          end
        end
        RX_DATA: begin
          if (mid_bit) begin
            us_cnt  <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              rx_state <= RX_STOP;
            end
          end else if (pluse_us) begin
            us_cnt <= us_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (mid_bit) begin
            // framing error drops the byte
            byte_vld <= rx_s2;
            us_cnt   <= '0;
            rx_state <= RX_IDLE;
          end else if (pluse_us) begin
            us_cnt <= us_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk_sys) begin
    if (rx_state == RX_DATA && mid_bit) begin
      rx_byte <= {rx_s2, rx_byte[7:1]};
    end
  end

  // ----------------------------------------
  // frame parser
  // ----------------------------------------
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      pstate   <= P_SYNC;
      cmdr_vld <= 1'b0;
    end else begin
      cmdr_vld <= 1'b0;
      if (byte_vld) begin
        case (pstate)
          P_SYNC: begin
            // bad sync just waits for the next byte
            if (rx_byte == SYNC_BYTE) begin
              pstate <= P_DEV;
            end
          end
          P_DEV:  pstate <= P_MOD;
          P_MOD:  pstate <= P_ADDR;
          P_ADDR: pstate <= P_DATA;
          P_DATA: pstate <= P_CHK;
          P_CHK: begin
            cmdr_vld <= (rx_byte == chk);
            pstate   <= P_SYNC;
          end
          default: pstate <= P_SYNC;
        endcase
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (byte_vld) begin
      case (pstate)
        P_DEV: begin
          cmdr_dev <= rx_byte;
          chk      <= rx_byte;
        end
        P_MOD: begin
          cmdr_mod <= rx_byte;
          chk      <= chk ^ rx_byte;
        end
        P_ADDR: begin
          cmdr_addr <= rx_byte;
          chk       <= chk ^ rx_byte;
        end
        P_DATA: begin
          cmdr_data <= rx_byte;
          chk       <= chk ^ rx_byte;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: verilog/tx_ctrl_top.sv
// frame serializer with sync insertion, checksum and bit clock counter
`timescale 1ns/1ps

module tx_ctrl_top import control_pkg::*; (
  output logic  tx_ctrl,
  input  byte_t cmdt_dev,
  input  byte_t cmdt_mod,
  input  byte_t cmdt_addr,
  input  byte_t cmdt_data,
  input  logic  cmdt_vld,
  input  logic  clk_sys,
  input  logic  rst
);

  localparam int NBITS = FRAME_BYTES * 10;
  localparam int CKW   = $clog2(BIT_CLKS);
  localparam int BW    = $clog2(NBITS);
  localparam logic [CKW-1:0] CLK_LAST = CKW'(BIT_CLKS - 1);
  localparam logic [BW-1:0]  BIT_LAST = BW'(NBITS - 1);

  tx_state_t        tx_state;
  logic [CKW-1:0]   clk_cnt;
  logic [BW-1:0]    bit_cnt;
  byte_t            frm [FRAME_BYTES];
  logic [NBITS-1:0] chars;
  logic [NBITS-1:0] sh;
  logic             bit_end;

  // ----------------------------------------
  // frame assembly
  // ----------------------------------------
  always_comb begin
    frm[0] = SYNC_BYTE;
    frm[1] = cmdt_dev;
    frm[2] = cmdt_mod;
    frm[3] = cmdt_addr;
    frm[4] = cmdt_data;
    frm[5] = cmdt_dev ^ cmdt_mod ^ cmdt_addr ^ cmdt_data;
    // start 0, data lsb first, stop 1
    for (int i = 0; i < FRAME_BYTES; i++) begin
      chars[i*10 +: 10] = {1'b1, frm[i], 1'b0};
    end
  end

  // ----------------------------------------
  // bit timing
  // ----------------------------------------
  assign bit_end = (tx_state == TX_SHIFT) && (clk_cnt == CLK_LAST);

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      tx_state <= TX_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
    end else begin
      case (tx_state)
        TX_IDLE: begin
          // busy periods simply ignore cmdt_vld
          if (cmdt_vld) begin
            tx_state <= TX_SHIFT;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
          end
        end
        TX_SHIFT: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_LAST) begin
              tx_state <= TX_IDLE;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (tx_state == TX_IDLE && cmdt_vld) begin
      sh <= chars;
    end else if (bit_end) begin
      sh <= {1'b1, sh[NBITS-1:1]};
    end
  end

  // idle line high
  assign tx_ctrl = (tx_state == TX_SHIFT) ? sh[0] : 1'b1;

endmodule

// File: verilog/factory_ctrl.sv
// command router with dev_id register and read reply builder
`timescale 1ns/1ps

module factory_ctrl import control_pkg::*; (
  input  byte_t cmdr_dev,
  input  byte_t cmdr_mod,
  input  byte_t cmdr_addr,
  input  byte_t cmdr_data,
  input  logic  cmdr_vld,
  output byte_t cmdt_dev,
  output byte_t cmdt_mod,
  output byte_t cmdt_addr,
  output byte_t cmdt_data,
  output logic  cmdt_vld,
  output byte_t cmdl_mod,
  output byte_t cmdl_addr,
  output byte_t cmdl_data,
  output logic  cmdl_vld,
  input  byte_t rd_data,
  input  logic  rd_vld,
  output byte_t dev_id,
  input  logic  clk_sys,
  input  logic  pluse_us,
  input  logic  rst
);

  logic is_fact;
  logic is_own;
  logic is_local;
  logic rd_pend;
  logic reply;

  // ----------------------------------------
  // routing decode
  // ----------------------------------------
  assign is_fact  = (cmdr_dev == DEV_FACTORY);
  assign is_own   = (cmdr_dev == dev_id);
  assign is_local = !is_fact && (is_own || cmdr_dev == DEV_BCAST);
  assign reply    = rd_vld && rd_pend;

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      dev_id   <= DEV_ID_RST;
      cmdl_vld <= 1'b0;
      cmdt_vld <= 1'b0;
      rd_pend  <= 1'b0;
    end else begin
      cmdl_vld <= 1'b0;
      cmdt_vld <= 1'b0;
      if (cmdr_vld) begin
        if (is_fact) begin
          dev_id <= cmdr_data;
        end else if (is_local) begin
          cmdl_vld <= 1'b1;
          // broadcast reads run on the bus but are not answered
          rd_pend  <= cmdr_mod[READ_BIT] && is_own;
        end else begin
          cmdt_vld <= 1'b1;
        end
      end else if (rd_vld) begin
        cmdt_vld <= rd_pend;
        rd_pend  <= 1'b0;
      end
    end
  end

  // local command that also serves as the reply header
  always_ff @(posedge clk_sys) begin
    if (cmdr_vld && is_local) begin
      cmdl_mod  <= cmdr_mod;
      cmdl_addr <= cmdr_addr;
      cmdl_data <= cmdr_data;
    end
  end

  // forward copy or read reply
  always_ff @(posedge clk_sys) begin
    if (cmdr_vld) begin
      cmdt_dev  <= cmdr_dev;
      cmdt_mod  <= cmdr_mod;
      cmdt_addr <= cmdr_addr;
      cmdt_data <= cmdr_data;
    end else if (reply) begin
      cmdt_dev  <= dev_id;
      cmdt_mod  <= cmdl_mod;
      cmdt_addr <= cmdl_addr;
      cmdt_data <= rd_data;
    end
  end

endmodule

// File: verilog/fx_bc.sv
// fx bus controller for single byte writes and reads with read data capture
`timescale 1ns/1ps

module fx_bc import control_pkg::*; (
  input  byte_t    cmdl_mod,
  input  byte_t    cmdl_addr,
  input  byte_t    cmdl_data,
  input  logic     cmdl_vld,
  output fx_addr_t fx_waddr,
  output fx_addr_t fx_raddr,
  output logic     fx_wr,
  output logic     fx_rd,
  output byte_t    fx_data,
  input  byte_t    fx_q,
  output byte_t    rd_data,
  output logic     rd_vld,
  input  logic     clk_sys,
  input  logic     rst
);

  logic     is_rd;
  logic     rd_wait;
  fx_addr_t cmd_addr;

  assign is_rd    = cmdl_mod[READ_BIT];
  // module bits 5..0 in the high byte
  assign cmd_addr = {2'b00, cmdl_mod[5:0], cmdl_addr};

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      fx_wr   <= 1'b0;
      fx_rd   <= 1'b0;
      rd_wait <= 1'b0;
      rd_vld  <= 1'b0;
    end else begin
      fx_wr   <= cmdl_vld && !is_rd;
      fx_rd   <= cmdl_vld && is_rd;
      rd_wait <= fx_rd;
      rd_vld  <= rd_wait;
    end
  end

  // addresses hold between strobes
  always_ff @(posedge clk_sys) begin
    if (cmdl_vld && is_rd) begin
      fx_raddr <= cmd_addr;
    end
    if (cmdl_vld && !is_rd) begin
      fx_waddr <= cmd_addr;
      fx_data  <= cmdl_data;
    end
    // fx_q valid one cycle after the read strobe
    if (rd_wait) begin
      rd_data <= fx_q;
    end
  end

endmodule

// File: verilog/cfg_reg.sv
// module 0 register block with mod_id readback and four scratch bytes
`timescale 1ns/1ps

module cfg_reg import control_pkg::*; (
  input  fx_addr_t fx_waddr,
  input  fx_addr_t fx_raddr,
  input  logic     fx_wr,
  input  logic     fx_rd,
  input  byte_t    fx_data,
  output byte_t    fx_q,
  input  mod_id_t  mod_id,
  input  logic     clk_sys,
  input  logic     rst
);

  byte_t scratch [1:4];
  byte_t rd_mux;
  logic  wr_hit;
  logic  rd_sel;

  assign wr_hit = fx_wr && (fx_waddr[15:8] == 8'(CFG_MOD));
  assign rd_sel = (fx_raddr[15:8] == 8'(CFG_MOD));

  // address 0 is read only
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      for (int i = 1; i <= 4; i++) begin
        scratch[i] <= '0;
      end
    end else if (wr_hit) begin
      case (fx_waddr[7:0])
        8'd1, 8'd2, 8'd3, 8'd4: scratch[fx_waddr[2:0]] <= fx_data;
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_mux = '0;
    if (rd_sel) begin
      case (fx_raddr[7:0])
        8'd0: rd_mux = {2'b00, mod_id};
        8'd1, 8'd2, 8'd3, 8'd4: rd_mux = scratch[fx_raddr[2:0]];
        default: rd_mux = '0;
      endcase
    end
  end

  // one cycle of data after fx_rd, zero otherwise so the OR stays clean
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      fx_q <= '0;
    end else begin
      fx_q <= fx_rd ? rd_mux : 8'h00;
    end
  end

endmodule

// File: verilog/control_top.sv
// command node top level with receiver, router, transmitter, bus controller and cfg block
`timescale 1ns/1ps

module control_top import control_pkg::*; (
  output logic     tx_ctrl,
  input  logic     rx_ctrl,
  output fx_addr_t fx_waddr,
  output fx_addr_t fx_raddr,
  output logic     fx_wr,
  output logic     fx_rd,
  output byte_t    fx_data,
  input  byte_t    fx_q,
  output byte_t    dev_id,
  input  mod_id_t  mod_id,
  input  logic     clk_sys,
  input  logic     pluse_us,
  input  logic     rst
);

  byte_t cmdr_dev;
  byte_t cmdr_mod;
  byte_t cmdr_addr;
  byte_t cmdr_data;
  logic  cmdr_vld;
  byte_t cmdt_dev;
  byte_t cmdt_mod;
  byte_t cmdt_addr;
  byte_t cmdt_data;
  logic  cmdt_vld;
  byte_t cmdl_mod;
  byte_t cmdl_addr;
  byte_t cmdl_data;
  logic  cmdl_vld;
  byte_t rd_data;
  logic  rd_vld;
  byte_t fx_q_ctrl;
  byte_t fx_q_all;

  // ----------------------------------------
  // line side
  // ----------------------------------------
  rx_ctrl_top u_rx_ctrl (
    .rx_ctrl   (rx_ctrl),
    .cmdr_dev  (cmdr_dev),
    .cmdr_mod  (cmdr_mod),
    .cmdr_addr (cmdr_addr),
    .cmdr_data (cmdr_data),
    .cmdr_vld  (cmdr_vld),
    .clk_sys   (clk_sys),
    .pluse_us  (pluse_us),
    .rst       (rst)
  );

  factory_ctrl u_factory_ctrl (
    .cmdr_dev  (cmdr_dev),
    .cmdr_mod  (cmdr_mod),
    .cmdr_addr (cmdr_addr),
    .cmdr_data (cmdr_data),
    .cmdr_vld  (cmdr_vld),
    .cmdt_dev  (cmdt_dev),
    .cmdt_mod  (cmdt_mod),
    .cmdt_addr (cmdt_addr),
    .cmdt_data (cmdt_data),
    .cmdt_vld  (cmdt_vld),
    .cmdl_mod  (cmdl_mod),
    .cmdl_addr (cmdl_addr),
    .cmdl_data (cmdl_data),
    .cmdl_vld  (cmdl_vld),
    .rd_data   (rd_data),
    .rd_vld    (rd_vld),
    .dev_id    (dev_id),
    .clk_sys   (clk_sys),
    .pluse_us  (pluse_us),
    .rst       (rst)
  );

  tx_ctrl_top u_tx_ctrl (
    .tx_ctrl   (tx_ctrl),
    .cmdt_dev  (cmdt_dev),
    .cmdt_mod  (cmdt_mod),
    .cmdt_addr (cmdt_addr),
    .cmdt_data (cmdt_data),
    .cmdt_vld  (cmdt_vld),
    .clk_sys   (clk_sys),
    .rst       (rst)
  );

  // ----------------------------------------
  // fx bus side
  // ----------------------------------------
  fx_bc u_fx_bc (
    .cmdl_mod  (cmdl_mod),
    .cmdl_addr (cmdl_addr),
    .cmdl_data (cmdl_data),
    .cmdl_vld  (cmdl_vld),
    .fx_waddr  (fx_waddr),
    .fx_raddr  (fx_raddr),
    .fx_wr     (fx_wr),
    .fx_rd     (fx_rd),
    .fx_data   (fx_data),
    .fx_q      (fx_q_all),
    .rd_data   (rd_data),
    .rd_vld    (rd_vld),
    .clk_sys   (clk_sys),
    .rst       (rst)
  );

  cfg_reg u_ctrl_reg (
    .fx_waddr (fx_waddr),
    .fx_raddr (fx_raddr),
    .fx_wr    (fx_wr),
    .fx_rd    (fx_rd),
    .fx_data  (fx_data),
    .fx_q     (fx_q_ctrl),
    .mod_id   (mod_id),
    .clk_sys  (clk_sys),
    .rst      (rst)
  );

  // internal block is zero outside its own reads
  assign fx_q_all = fx_q_ctrl | fx_q;

endmodule

// File: tb/control_top_sva.sv
// fx strobe and reset line checks bound to the command node top level
`timescale 1ns/1ps

module control_top_sva (
  input logic clk_sys,
  input logic rst,
  input logic fx_wr,
  input logic fx_rd,
  input logic tx_ctrl
);

  // ----------------------------------------
  // fx bus strobes
  // ----------------------------------------
  a_strobe_excl: assert property (@(posedge clk_sys) disable iff (rst) !(fx_wr && fx_rd))
    else $error("fx_wr and fx_rd are high in the same cycle");

  // single cycle strobes
  a_wr_pulse: assert property (@(posedge clk_sys) disable iff (rst) fx_wr |=> !fx_wr)
    else $error("fx_wr stays high for two cycles");

  a_rd_pulse: assert property (@(posedge clk_sys) disable iff (rst) fx_rd |=> !fx_rd)
    else $error("fx_rd stays high for two cycles");

  // ----------------------------------------
  // line idle while in reset
  // ----------------------------------------
  a_tx_idle: assert property (@(posedge clk_sys) rst |=> tx_ctrl)
    else $error("tx_ctrl is not high during reset");

endmodule

bind control_top control_top_sva u_sva (
  .clk_sys (clk_sys),
  .rst     (rst),
  .fx_wr   (fx_wr),
  .fx_rd   (fx_rd),
  .tx_ctrl (tx_ctrl)
);

// File: tb/tb_control_top.sv
// testbench with serial frame driver, fx memory model, reply decoder, routing model and report
`timescale 1ns/1ps

module tb_control_top import control_pkg::*; ();

  localparam int N_EXT       = 4;
  localparam int N_FWD       = 4;
  localparam int N_FRAMES    = 2 * N_EXT + 9 + N_FWD + 4 + 3 + 2;
  localparam int FRAME_CLKS  = FRAME_BYTES * 10 * BIT_CLKS;
  localparam int WATCHDOG_NS = N_FRAMES * 3 * FRAME_CLKS * 40;

  logic     clk_sys;
  logic     rst;
  logic     pluse_us;
  logic     rx_ctrl;
  logic     tx_ctrl;
  fx_addr_t fx_waddr;
  fx_addr_t fx_raddr;
  logic     fx_wr;
  logic     fx_rd;
  byte_t    fx_data;
  byte_t    fx_q;
  byte_t    dev_id;
  mod_id_t  mod_id;

  logic [31:0] lfsr_state = 32'h4d73;
  int          errors;
  int          checks;
  int          ntests;
  byte_t       model_id;
  byte_t       ext_mem [256];
  byte_t       ref_mem [256];
  byte_t       scratch_m [1:4];
  // expected frames packed as dev, mod, addr, data
  logic [31:0] exp_frames [$];
  logic        exp_kind [$];
  fx_addr_t    exp_addr [$];
  byte_t       exp_data [$];

  control_top u_dut (
    .tx_ctrl  (tx_ctrl),
    .rx_ctrl  (rx_ctrl),
    .fx_waddr (fx_waddr),
    .fx_raddr (fx_raddr),
    .fx_wr    (fx_wr),
    .fx_rd    (fx_rd),
    .fx_data  (fx_data),
    .fx_q     (fx_q),
    .dev_id   (dev_id),
    .mod_id   (mod_id),
    .clk_sys  (clk_sys),
    .pluse_us (pluse_us),
    .rst      (rst)
  );

  // ----------------------------------------
  // clock, us strobe, watchdog
  // ----------------------------------------
  initial begin
    clk_sys = 1'b0;
    forever #20 clk_sys = ~clk_sys;
  end

  initial begin
    pluse_us = 1'b0;
    forever begin
      repeat (24) @(posedge clk_sys);
      pluse_us <= 1'b1;
      @(posedge clk_sys);
      pluse_us <= 1'b0;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog timeout, the tests did not finish in time");
    $display("Something failed");
    $finish;
  end

  // ----------------------------------------
  // random numbers
  // ----------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic byte_t rand_byte();
    logic [31:0] v;
    v = take_bits(8);
    return v[7:0];
  endfunction

  // draws external modules and never module 0
  function automatic mod_id_t rand_module();
    logic [31:0] v;
    v = take_bits(6);
    return (v[5:0] == 6'd0) ? 6'd1 : v[5:0];
  endfunction

  function automatic byte_t rand_other_dev();
    byte_t d;
    d = rand_byte();
    while (d == DEV_FACTORY || d == DEV_BCAST || d == model_id) begin
      d = rand_byte();
    end
    return d;
  endfunction

  function automatic byte_t not_sync(input byte_t b);
    return (b == SYNC_BYTE) ? 8'h3C : b;
  endfunction

  function automatic byte_t fill_value(input int i);
    return 8'(i * 37 + 11);
  endfunction

  task automatic compare_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t ns %s expected %h actual %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // ----------------------------------------
  // fx bus slave and strobe monitor
  // ----------------------------------------
  initial begin
    fx_q = '0;
    for (int i = 0; i < 256; i++) begin
      ext_mem[i] = fill_value(i);
    end
    forever begin
      @(posedge clk_sys);
      if (fx_wr === 1'b1 && fx_waddr[15:8] != 8'h00) begin
        ext_mem[fx_waddr[7:0]] <= fx_data;
      end
      if (fx_rd === 1'b1 && fx_raddr[15:8] != 8'h00) begin
        fx_q <= ext_mem[fx_raddr[7:0]];
      end else begin
        fx_q <= 8'h00;
      end
    end
  end

  always @(negedge clk_sys) begin : strobe_mon
    logic     k;
    fx_addr_t a;
    byte_t    d;
    if (rst === 1'b0 && (fx_wr === 1'b1 || fx_rd === 1'b1)) begin
      assert (exp_kind.size() != 0) else begin
        $display("ERROR at %0t ns: fx bus strobe without a matching command", $time);
        errors++;
      end
      if (exp_kind.size() != 0) begin
        k = exp_kind.pop_front();
        a = exp_addr.pop_front();
        d = exp_data.pop_front();
        compare_value("fx_rd", 16'(k), 16'(fx_rd));
        compare_value("fx_wr", 16'(!k), 16'(fx_wr));
        if (k) begin
          compare_value("fx_raddr", a, fx_raddr);
        end else begin
          compare_value("fx_waddr", a, fx_waddr);
          compare_value("fx_data", 16'(d), 16'(fx_data));
        end
      end
    end
  end

  // ----------------------------------------
  // tx_ctrl decoder
  // ----------------------------------------
  task automatic read_char(output byte_t b);
    @(negedge clk_sys);
    while (tx_ctrl !== 1'b0) begin
      @(negedge clk_sys);
    end
    repeat (BIT_CLKS / 2) @(negedge clk_sys);
    assert (tx_ctrl === 1'b0) else begin
      $display("ERROR at %0t ns: start bit on tx_ctrl is too short", $time);
      errors++;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk_sys);
      b[i] = tx_ctrl;
    end
    repeat (BIT_CLKS) @(negedge clk_sys);
    assert (tx_ctrl === 1'b1) else begin
      $display("ERROR at %0t ns: missing stop bit on tx_ctrl", $time);
      errors++;
    end
  endtask

  initial begin : decoder
    byte_t       fb [FRAME_BYTES];
    byte_t       eb [FRAME_BYTES];
    logic [31:0] ef;
    wait (rst === 1'b0);
    forever begin
      for (int k = 0; k < FRAME_BYTES; k++) begin
        read_char(fb[k]);
      end
      assert (exp_frames.size() != 0) else begin
        $display("ERROR at %0t ns: frame on tx_ctrl that no command asked for", $time);
        errors++;
      end
      if (exp_frames.size() != 0) begin
        ef = exp_frames.pop_front();
        eb[0] = SYNC_BYTE;
        eb[1] = ef[31:24];
        eb[2] = ef[23:16];
        eb[3] = ef[15:8];
        eb[4] = ef[7:0];
        eb[5] = ef[31:24] ^ ef[23:16] ^ ef[15:8] ^ ef[7:0];
        for (int k = 0; k < FRAME_BYTES; k++) begin
          compare_value($sformatf("tx_ctrl byte %0d", k), 16'(eb[k]), 16'(fb[k]));
        end
      end
    end
  end

  // ----------------------------------------
  // routing model and frame driver
  // ----------------------------------------
  task automatic predict(input byte_t dev, input byte_t mod, input byte_t addr,
                         input byte_t data);
    fx_addr_t a;
    byte_t    rv;
    a = {2'b00, mod[5:0], addr};
    rv = 8'h00;
    if (dev == DEV_FACTORY) begin
      model_id = data;
    end else if (dev == model_id || dev == DEV_BCAST) begin
      exp_kind.push_back(mod[READ_BIT]);
      exp_addr.push_back(a);
      exp_data.push_back(data);
      if (mod[READ_BIT]) begin
        if (mod[5:0] != 6'd0) rv = ref_mem[addr];
        else if (addr == 8'd0) rv = {2'b00, mod_id};
        else if (addr >= 8'd1 && addr <= 8'd4) rv = scratch_m[addr[2:0]];
        // replies only for reads addressed to this node
        if (dev == model_id) begin
          exp_frames.push_back({model_id, mod, addr, rv});
        end
      end else if (mod[5:0] != 6'd0) begin
        ref_mem[addr] = data;
      end else if (addr >= 8'd1 && addr <= 8'd4) begin
        scratch_m[addr[2:0]] = data;
      end
    end else begin
      exp_frames.push_back({dev, mod, addr, data});
    end
  endtask

  task automatic send_byte(input byte_t b);
    logic [9:0] ch;
    ch = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_sys);
      rx_ctrl <= ch[i];
      repeat (BIT_CLKS - 1) @(posedge clk_sys);
    end
  endtask

  task automatic send_frame(input byte_t sync, input byte_t dev, input byte_t mod,
                            input byte_t addr, input byte_t data, input byte_t chk);
    send_byte(sync);
    send_byte(dev);
    send_byte(mod);
    send_byte(addr);
    send_byte(data);
    send_byte(chk);
  endtask

  // wait for any reply or forward, then leave the line idle
  task automatic settle();
    int n;
    n = 0;
    while (exp_frames.size() != 0 && n < 2 * FRAME_CLKS) begin
      @(negedge clk_sys);
      n++;
    end
    assert (exp_frames.size() == 0) else begin
      $display("ERROR at %0t ns: expected frame never appeared on tx_ctrl", $time);
      errors++;
      exp_frames.delete();
    end
    repeat (3 * BIT_CLKS) @(negedge clk_sys);
    assert (exp_kind.size() == 0) else begin
      $display("ERROR at %0t ns: expected fx bus strobe did not happen", $time);
      errors++;
      exp_kind.delete();
      exp_addr.delete();
      exp_data.delete();
    end
    compare_value("dev_id", 16'(model_id), 16'(dev_id));
  endtask

  // tx_ctrl stays high for a whole frame time
  task automatic expect_idle_line();
    int n;
    n = 0;
    while (tx_ctrl === 1'b1 && n < FRAME_CLKS) begin
      @(negedge clk_sys);
      n++;
    end
    checks++;
    assert (tx_ctrl === 1'b1) else begin
      $display("ERROR at %0t ns: tx_ctrl sends a frame that no command asked for", $time);
      errors++;
    end
  endtask

  task automatic send_cmd(input byte_t dev, input byte_t mod, input byte_t addr,
                          input byte_t data);
    predict(dev, mod, addr, data);
    send_frame(SYNC_BYTE, dev, mod, addr, data, dev ^ mod ^ addr ^ data);
    settle();
  endtask

  task automatic finish_test(input string name, input int base);
    ntests++;
    $display("test %s done with %0d errors", name, errors - base);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : stimulus
    logic [31:0] r;
    int          base;
    mod_id_t     m;
    byte_t       a;
    byte_t       d;
    byte_t       old_id;
    rst = 1'b1;
    rx_ctrl = 1'b1;
    mod_id = '0;
    errors = 0;
    checks = 0;
    ntests = 0;
    model_id = DEV_ID_RST;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = fill_value(i);
    end
    for (int i = 1; i <= 4; i++) begin
      scratch_m[i] = 8'h00;
    end
    @(posedge clk_sys);
    r = take_bits(6);
    mod_id <= r[5:0];
    repeat (7) @(posedge clk_sys);
    rst <= 1'b0;
    repeat (4) @(negedge clk_sys);

    base = errors;
    compare_value("dev_id", 16'(DEV_ID_RST), 16'(dev_id));
    compare_value("tx_ctrl", 16'h1, 16'(tx_ctrl));
    finish_test("reset", base);

    base = errors;
    for (int i = 0; i < N_EXT; i++) begin
      m = rand_module();
      a = rand_byte();
      d = rand_byte();
      send_cmd(model_id, {2'b00, m}, a, d);
      send_cmd(model_id, {2'b10, m}, a, rand_byte());
    end
    finish_test("external write and read", base);

    base = errors;
    send_cmd(model_id, 8'h80, 8'h00, 8'h00);
    for (int i = 1; i <= 4; i++) begin
      send_cmd(model_id, 8'h00, 8'(i), rand_byte());
    end
    for (int i = 1; i <= 4; i++) begin
      send_cmd(model_id, 8'h80, 8'(i), 8'h00);
    end
    finish_test("cfg registers", base);

    base = errors;
    for (int i = 0; i < N_FWD; i++) begin
      send_cmd(rand_other_dev(), rand_byte(), rand_byte(), rand_byte());
    end
    finish_test("forward", base);

    base = errors;
    m = rand_module();
    a = rand_byte();
    d = rand_byte();
    // a corrupted checksum followed by a valid read
    send_frame(SYNC_BYTE, model_id, {2'b00, m}, a, d, model_id ^ {2'b00, m} ^ a ^ d ^ 8'h10);
    settle();
    expect_idle_line();
    send_cmd(model_id, {2'b10, m}, a, 8'h00);
    // no byte of the bad frame may look like a sync
    send_frame(8'h5A, not_sync(model_id), not_sync({2'b00, m}), not_sync(a), not_sync(d),
               not_sync(rand_byte()));
    settle();
    expect_idle_line();
    send_cmd(model_id, {2'b00, m}, a, rand_byte());
    finish_test("bad frames", base);

    base = errors;
    old_id = model_id;
    send_cmd(DEV_FACTORY, rand_byte(), rand_byte(), rand_other_dev());
    m = rand_module();
    send_cmd(old_id, {2'b00, m}, rand_byte(), rand_byte());
    send_cmd(model_id, 8'h80, 8'h00, 8'h00);
    finish_test("factory dev_id", base);

    base = errors;
    m = rand_module();
    a = rand_byte();
    send_cmd(DEV_BCAST, {2'b00, m}, a, rand_byte());
    send_cmd(DEV_BCAST, {2'b10, m}, a, 8'h00);
    expect_idle_line();
    finish_test("broadcast", base);

    $display("tests %0d, checks %0d, errors %0d", ntests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: list.f
verilog/control_pkg.sv
verilog/rx_ctrl_top.sv
verilog/tx_ctrl_top.sv
verilog/factory_ctrl.sv
verilog/fx_bc.sv
verilog/cfg_reg.sv
verilog/control_top.sv
tb/control_top_sva.sv
tb/tb_control_top.sv

// File: Makefile
SIM  := obj_dir/Vtb_control_top
SRCS := $(filter-out +%,$(shell cat list.f))

.PHONY: all run clean

all: run

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_control_top -f list.f

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
